// ==== design/cpu_params.svh ====
// ==========================================================
// cpu parameters
// word and address widths, register count and the pc value
// held during reset
// ==========================================================
`ifndef CPU_PARAMS_SVH
`define CPU_PARAMS_SVH

// data word and register width
`define DATA_WIDTH 16

// memory bus address width
`define ADDR_WIDTH 16

// general registers
`define REG_COUNT 8

// register index width
`define REG_IDX_WIDTH $clog2(`REG_COUNT)

// pc parks at all ones, so the first increment fetches word 0
`define RESET_PC {`ADDR_WIDTH{1'b1}}

`endif

// ==== design/isa_pkg.sv ====
// ==========================================================
// instruction set types
// major opcodes, alu codes, branch conditions and the
// two 16-bit instruction layouts
// ==========================================================
package isa_pkg;

    // 5-bit major opcode
    // alu is 00??? / 010??, branch is 10???, both matched by pattern
    typedef enum logic [4:0] {
        OP_LOAD  = 5'b01100,
        OP_STORE = 5'b01101,
        OP_PUSH  = 5'b01110,
        OP_POP   = 5'b01111
    } major_op_e;

    // alu code, instruction bits 14..11
    // codes 8 to 11 are reserved
    typedef enum logic [3:0] {
        ALU_ADD  = 4'd0,
        ALU_SUB  = 4'd1,
        ALU_AND  = 4'd2,
        ALU_OR   = 4'd3,
        ALU_XOR  = 4'd4,
        ALU_MOVB = 4'd5,
        ALU_SHL  = 4'd6,
        ALU_SHR  = 4'd7
    } alu_op_e;

    // branch conditions, arm-like order
    typedef enum logic [3:0] {
        COND_EQ, COND_NE, COND_CS, COND_CC,
        COND_MI, COND_PL, COND_VS, COND_VC,
        COND_HI, COND_LS, COND_GE, COND_LT,
        COND_GT, COND_LE, COND_AL, COND_NV
    } cond_e;

    // alu and load/store layout
    // operand bits 4..3 are the mode, 3..0 the immediate, 2..0 rb
    typedef struct packed {
        major_op_e  op;
        logic [2:0] rd;
        logic [2:0] ra;
        logic [4:0] operand;
    } instr_t;

    // short branch layout
    typedef struct packed {
        logic [1:0]        prefix;
        cond_e             cond;
        logic signed [9:0] offset;
    } branch_t;

endpackage

// ==== design/core_pkg.sv ====
// ==========================================================
// core microarchitecture types
// sequencer states, flags and the structs passed between
// fetch, execute and the memory bus
// ==========================================================
`include "cpu_params.svh"

package core_pkg;

    typedef enum logic [1:0] {
        DECODE,
        LS1,
        LS2,
        BRANCH_DELAY
    } seq_state_e;

    // condition flags
    typedef struct packed {
        logic n;
        logic z;
        logic c;
        logic v;
    } flags_t;

    // memory bus as it leaves the core
    typedef struct packed {
        logic [`ADDR_WIDTH-1:0] addr;
        logic [`DATA_WIDTH-1:0] wdata;
        logic                   re;
        logic                   we;
    } mem_req_t;

    // data access from execute
    typedef struct packed {
        logic [`ADDR_WIDTH-1:0] addr;
        logic [`DATA_WIDTH-1:0] wdata;
        logic                   load;
        logic                   store;
    } ls_req_t;

    // taken branch steering
    typedef struct packed {
        logic                   take;
        logic [`ADDR_WIDTH-1:0] target;
    } redirect_t;

endpackage

// ==== design/fetch_unit.sv ====
// ==========================================================
// fetch unit
// program counter, fetch-valid tracking and the shared bus
// mux between instruction fetch and data access
// ==========================================================
`include "cpu_params.svh"

module fetch_unit (
    input  logic                   clk,
    input  logic                   rst,
    input  logic                   stall,
    input  core_pkg::redirect_t    redirect,
    input  core_pkg::ls_req_t      ls_req,
    output core_pkg::mem_req_t     mem_req,
    output logic [`ADDR_WIDTH-1:0] pc,
    output logic                   fetch_valid
);
    logic [`ADDR_WIDTH-1:0] pc_next;
    logic                   ls_active;

    // data access owns the bus this cycle
    assign ls_active = ls_req.load | ls_req.store;

    // next fetch address
    // stall holds, branch steers, otherwise step by one
    always_comb begin
        if (stall) begin
            pc_next = pc;
        end else if (redirect.take) begin
            pc_next = redirect.target;
        end else begin
            pc_next = pc + 1'b1;
        end
    end

    // bus select
    // fetch reads at pc_next so the word lands as pc catches up
    always_comb begin
        mem_req.addr  = ls_active ? ls_req.addr : pc_next;
        mem_req.wdata = ls_req.wdata;
        mem_req.re    = !rst && (ls_active ? ls_req.load : 1'b1);
        mem_req.we    = !rst && ls_req.store;
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            pc          <= `RESET_PC;
            fetch_valid <= 1'b0;
        end else begin
            pc          <= pc_next;
            // returning word is an instruction only if fetch had the bus
            fetch_valid <= !ls_active;
        end
    end

endmodule

// ==== design/exec_unit.sv ====
// ==========================================================
// execute unit
// instruction register, sequencer, operand select, branch
// evaluation, load/store sequencing and the flag register
// ==========================================================
`include "cpu_params.svh"

module exec_unit (
    input  logic                      clk,
    input  logic                      rst,
    input  logic [`DATA_WIDTH-1:0]    rdata,
    input  logic [`ADDR_WIDTH-1:0]    pc,
    input  logic                      fetch_valid,
    output logic [`REG_IDX_WIDTH-1:0] ra_addr,
    output logic [`REG_IDX_WIDTH-1:0] rb_addr,
    output logic [`REG_IDX_WIDTH-1:0] rd_addr,
    input  logic [`DATA_WIDTH-1:0]    ra_data,
    input  logic [`DATA_WIDTH-1:0]    rb_data,
    input  logic [`DATA_WIDTH-1:0]    rd_data,
    output logic                      wr_en,
    output logic [`DATA_WIDTH-1:0]    wr_data,
    output isa_pkg::alu_op_e          alu_op,
    output logic [`DATA_WIDTH-1:0]    alu_a,
    output logic [`DATA_WIDTH-1:0]    alu_b,
    input  logic [`DATA_WIDTH-1:0]    alu_result,
    input  core_pkg::flags_t          alu_flags,
    output core_pkg::flags_t          flags,
    output core_pkg::redirect_t       redirect,
    output logic                      stall,
    output core_pkg::ls_req_t         ls_req
);
    import isa_pkg::*;
    import core_pkg::*;

    instr_t                 ir;
    logic                   ir_valid;
    branch_t                br;
    seq_state_e             state;
    seq_state_e             state_next;
    flags_t                 flags_next;
    logic [1:0]             mode;
    logic                   mode_ok;
    logic                   is_ls;
    logic                   cond_true;
    logic [`DATA_WIDTH-1:0] imm;
    logic [`ADDR_WIDTH-1:0] target;

    // field views of the instruction register
    assign br      = branch_t'(ir);
    assign mode    = ir.operand[4:3];
    // mode 11 was the long-immediate / special form, now a no-op
    assign mode_ok = (mode != 2'b11);
    assign is_ls   = (ir.op == OP_LOAD) || (ir.op == OP_STORE);
    assign imm     = {{(`DATA_WIDTH-4){ir.operand[3]}}, ir.operand[3:0]};
    // pc already points past the branch
    assign target  = pc + {{(`ADDR_WIDTH-10){br.offset[9]}}, br.offset};

    // register file addressing straight from the fields
    assign ra_addr = ir.ra;
    assign rb_addr = ir.operand[2:0];
    assign rd_addr = ir.rd;

    // operands, address generation reuses the adder
    assign alu_a  = ra_data;
    assign alu_b  = mode[1] ? rb_data : imm;
    assign alu_op = is_ls ? ALU_ADD : alu_op_e'(ir.op[3:0]);

    // condition check against the flag register
    always_comb begin
        case (br.cond)
            COND_EQ: cond_true = flags.z;
            COND_NE: cond_true = !flags.z;
            COND_CS: cond_true = flags.c;
            COND_CC: cond_true = !flags.c;
            COND_MI: cond_true = flags.n;
            COND_PL: cond_true = !flags.n;
            COND_VS: cond_true = flags.v;
            COND_VC: cond_true = !flags.v;
            // hi and ls look at v, not c
            COND_HI: cond_true = flags.v && !flags.z;
            COND_LS: cond_true = !flags.v || flags.z;
            COND_GE: cond_true = (flags.n == flags.v);
            COND_LT: cond_true = (flags.n != flags.v);
            COND_GT: cond_true = !flags.z && (flags.n == flags.v);
            COND_LE: cond_true = flags.z || (flags.n != flags.v);
            COND_AL: cond_true = 1'b1;
            default: cond_true = 1'b0;
        endcase
    end

    // sequencer
    always_comb begin
        state_next      = state;
        flags_next      = flags;
        stall           = 1'b0;
        wr_en           = 1'b0;
        wr_data         = alu_result;
        redirect.take   = 1'b0;
        redirect.target = target;
        ls_req.addr     = alu_result;
        ls_req.wdata    = rd_data;
        ls_req.load     = 1'b0;
        ls_req.store    = 1'b0;

        case (state)
            DECODE: begin
                // bubble when no valid word was loaded
                if (ir_valid) begin
                    casez (ir.op)
                        5'b00???: begin
                            if (mode_ok) begin
                                wr_en      = 1'b1;
                                flags_next = alu_flags;
                            end
                        end
                        // alu codes 8 to 11 are reserved
                        5'b010??: ;
                        OP_LOAD, OP_STORE: begin
                            if (mode_ok) begin
                                // bus goes to the data access, pc frozen
                                stall        = 1'b1;
                                ls_req.load  = (ir.op == OP_LOAD);
                                ls_req.store = (ir.op == OP_STORE);
                                state_next   = LS1;
                            end
                        end
                        OP_PUSH, OP_POP: ;
                        5'b10???: begin
                            redirect.take = cond_true;
                            // word already in flight gets dropped
                            if (cond_true) begin
                                state_next = BRANCH_DELAY;
                            end
                        end
                        default: ;
                    endcase
                end
            end
            LS1: begin
                // data is on rdata now, fetch restarts at the held pc
                stall      = 1'b1;
                state_next = LS2;
                if (ir.op == OP_LOAD) begin
                    wr_en   = 1'b1;
                    wr_data = rdata;
                end
            end
            // wait for the refetched word
            LS2: state_next = DECODE;
            BRANCH_DELAY: state_next = DECODE;
            default: state_next = DECODE;
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state    <= DECODE;
            flags    <= '0;
            ir_valid <= 1'b0;
        end else begin
            state <= state_next;
            flags <= flags_next;
            if (state_next == DECODE) begin
                ir_valid <= fetch_valid;
            end
        end
    end

    // ir holds while a multi-cycle instruction runs
    always_ff @(posedge clk) begin
        if (state_next == DECODE) begin
            ir <= instr_t'(rdata);
        end
    end

endmodule

// ==== design/regfile.sv ====
// ==========================================================
// register file
// eight general registers, three combinational read ports
// and one clocked write port addressed by rd
// ==========================================================
`include "cpu_params.svh"

module regfile (
    input  logic                      clk,
    input  logic                      rst,
    input  logic [`REG_IDX_WIDTH-1:0] ra_addr,
    input  logic [`REG_IDX_WIDTH-1:0] rb_addr,
    input  logic [`REG_IDX_WIDTH-1:0] rd_addr,
    output logic [`DATA_WIDTH-1:0]    ra_data,
    output logic [`DATA_WIDTH-1:0]    rb_data,
    output logic [`DATA_WIDTH-1:0]    rd_data,
    input  logic                      wr_en,
    input  logic [`DATA_WIDTH-1:0]    wr_data
);
    logic [`DATA_WIDTH-1:0] regs [`REG_COUNT];

    // reads see the old value during a write cycle
    assign ra_data = regs[ra_addr];
    assign rb_data = regs[rb_addr];
    // rd port feeds store data
    assign rd_data = regs[rd_addr];

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < `REG_COUNT; i++) begin
                regs[i] <= '0;
            end
        end else if (wr_en) begin
            regs[rd_addr] <= wr_data;
        end
    end

endmodule

// ==== design/alu.sv ====
// ==========================================================
// alu
// eight combinational operations with n/z/c/v generation
// ==========================================================
`include "cpu_params.svh"

module alu (
    input  isa_pkg::alu_op_e       op,
    input  logic [`DATA_WIDTH-1:0] a,
    input  logic [`DATA_WIDTH-1:0] b,
    input  core_pkg::flags_t       flags_in,
    output logic [`DATA_WIDTH-1:0] result,
    output core_pkg::flags_t       flags_out
);
    import isa_pkg::*;

    localparam int MSB     = `DATA_WIDTH - 1;
    localparam int SHAMT_W = $clog2(`DATA_WIDTH);

    // one extra bit for carry out
    logic [`DATA_WIDTH:0] wide;

    always_comb begin
        wide      = '0;
        result    = a;
        flags_out = flags_in;

        case (op)
            ALU_ADD: begin
                wide        = {1'b0, a} + {1'b0, b};
                result      = wide[MSB:0];
                flags_out.c = wide[`DATA_WIDTH];
                flags_out.v = (a[MSB] == b[MSB]) && (result[MSB] != a[MSB]);
            end
            ALU_SUB: begin
                // a + ~b + 1, carry set means no borrow
                wide        = {1'b0, a} + {1'b0, ~b} + 1'b1;
                result      = wide[MSB:0];
                flags_out.c = wide[`DATA_WIDTH];
                flags_out.v = (a[MSB] != b[MSB]) && (result[MSB] != a[MSB]);
            end
            ALU_AND:  result = a & b;
            ALU_OR:   result = a | b;
            ALU_XOR:  result = a ^ b;
            ALU_MOVB: result = b;
            ALU_SHL:  result = a << b[SHAMT_W-1:0];
            ALU_SHR:  result = a >> b[SHAMT_W-1:0];
            // reserved codes pass a through
            default:  result = a;
        endcase

        // n and z always follow the result
        flags_out.n = result[MSB];
        flags_out.z = (result == '0);
    end

endmodule

// ==== design/cpu_top.sv ====
// ==========================================================
// cpu top
// two-stage 16-bit core on one shared memory bus
// fetch, execute, alu and register file
// ==========================================================
`include "cpu_params.svh"

module cpu_top (
    input  logic                   clk,
    input  logic                   rst,
    input  logic [`DATA_WIDTH-1:0] rdata,
    output core_pkg::mem_req_t     mem_req
);
    import isa_pkg::*;
    import core_pkg::*;

    // fetch <-> execute
    logic                   stall;
    redirect_t              redirect;
    ls_req_t                ls_req;
    logic [`ADDR_WIDTH-1:0] pc;
    logic                   fetch_valid;

    // register file ports
    logic [`REG_IDX_WIDTH-1:0] ra_addr;
    logic [`REG_IDX_WIDTH-1:0] rb_addr;
    logic [`REG_IDX_WIDTH-1:0] rd_addr;
    logic [`DATA_WIDTH-1:0]    ra_data;
    logic [`DATA_WIDTH-1:0]    rb_data;
    logic [`DATA_WIDTH-1:0]    rd_data;
    logic                      wr_en;
    logic [`DATA_WIDTH-1:0]    wr_data;

    // alu ports
    alu_op_e                alu_op;
    logic [`DATA_WIDTH-1:0] alu_a;
    logic [`DATA_WIDTH-1:0] alu_b;
    logic [`DATA_WIDTH-1:0] alu_result;
    flags_t                 alu_flags;
    flags_t                 flags;

    fetch_unit u_fetch (
        .clk         (clk),
        .rst         (rst),
        .stall       (stall),
        .redirect    (redirect),
        .ls_req      (ls_req),
        .mem_req     (mem_req),
        .pc          (pc),
        .fetch_valid (fetch_valid)
    );

    exec_unit u_exec (
        .clk         (clk),
        .rst         (rst),
        .rdata       (rdata),
        .pc          (pc),
        .fetch_valid (fetch_valid),
        .ra_addr     (ra_addr),
        .rb_addr     (rb_addr),
        .rd_addr     (rd_addr),
        .ra_data     (ra_data),
        .rb_data     (rb_data),
        .rd_data     (rd_data),
        .wr_en       (wr_en),
        .wr_data     (wr_data),
        .alu_op      (alu_op),
        .alu_a       (alu_a),
        .alu_b       (alu_b),
        .alu_result  (alu_result),
        .alu_flags   (alu_flags),
        .flags       (flags),
        .redirect    (redirect),
        .stall       (stall),
        .ls_req      (ls_req)
    );

    regfile u_regs (
        .clk     (clk),
        .rst     (rst),
        .ra_addr (ra_addr),
        .rb_addr (rb_addr),
        .rd_addr (rd_addr),
        .ra_data (ra_data),
        .rb_data (rb_data),
        .rd_data (rd_data),
        .wr_en   (wr_en),
        .wr_data (wr_data)
    );

    alu u_alu (
        .op        (alu_op),
        .a         (alu_a),
        .b         (alu_b),
        .flags_in  (flags),
        .result    (alu_result),
        .flags_out (alu_flags)
    );

endmodule

// ==== tests/tb_clock.sv ====
// ==========================================================
// testbench clock and reset
// 4 ns clock, reset held for five cycles on request
// ==========================================================
module tb_clock (
    output logic clk,
    output logic rst
);
    timeunit 1ns;
    timeprecision 100ps;

    initial begin
        clk = 1'b0;
        rst = 1'b1;
    end

    always #2 clk = ~clk;

    // raise reset on a falling edge
    task automatic assert_reset();
        @(negedge clk);
        rst = 1'b1;
    endtask

    // drop reset five cycles later
    task automatic release_reset();
        repeat (5) @(negedge clk);
        rst = 1'b0;
    endtask

endmodule

// ==== tests/cpu_chk.sv ====
// ==========================================================
// execute unit checker
// data access and sequencer rules, bound into the execute
// unit of the core
// ==========================================================
module cpu_chk (
    input logic                 clk,
    input logic                 rst,
    input core_pkg::seq_state_e state,
    input core_pkg::ls_req_t    ls_req
);
    timeunit 1ns;
    timeprecision 100ps;

    import core_pkg::*;

    // assertion failures seen so far
    int fail_count = 0;

    // read and write strobes never together on the bus
    a_no_rd_wr: assert property (@(posedge clk)
        !(ls_req.load === 1'b1 && ls_req.store === 1'b1))
        else begin
            $error("load and store requested in the same cycle");
            fail_count++;
        end

    // no write strobe while in reset
    a_no_wr_rst: assert property (@(posedge clk)
        rst |-> (ls_req.store !== 1'b1))
        else begin
            $error("store requested during reset");
            fail_count++;
        end

    // delay slot lasts exactly one cycle
    a_delay_one: assert property (@(posedge clk) disable iff (rst)
        (state == BRANCH_DELAY) |=> (state == DECODE))
        else begin
            $error("branch delay not followed by decode");
            fail_count++;
        end

endmodule

// ==== tests/cpu_tb.sv ====
// ==========================================================
// cpu testbench
// memory model, instruction encoders and directed tests for
// fetch, alu, branches, load/store and random alu programs
// ==========================================================
`include "cpu_params.svh"

module cpu_tb;
    timeunit 1ns;
    timeprecision 100ps;

    import core_pkg::*;

    localparam int DONE_LIMIT = 2000;

    logic                   clk;
    logic                   rst;
    logic [`DATA_WIDTH-1:0] rdata;
    mem_req_t               mem_req;

    logic [`DATA_WIDTH-1:0] mem [256];
    logic [7:0]             rd_q;
    int                     wp;
    int                     errors;
    logic [31:0]            rng;

    tb_clock clk_gen (.clk(clk), .rst(rst));

    cpu_top dut0 (.clk(clk), .rst(rst), .rdata(rdata), .mem_req(mem_req));

    bind exec_unit cpu_chk u_chk (.clk(clk), .rst(rst), .state(state), .ls_req(ls_req));

    // write and address capture at the rising edge
    always @(posedge clk) begin
        if (mem_req.we) begin
            mem[mem_req.addr[7:0]] <= mem_req.wdata;
        end
        rd_q <= mem_req.addr[7:0];
    end

    // read data driven half a cycle later
    always @(negedge clk) begin
        rdata <= mem[rd_q];
    end

    // a failed bound assertion ends the run
    always @(negedge clk) begin
        if (dut0.u_exec.u_chk.fail_count != 0) begin
            $display("bound assertion in the execute unit checker failed");
            $display("TEST FAILED");
            $fatal(1);
        end
    end

    // encoders
    function automatic logic [15:0] alu_i(int code, int rd, int ra, int imm);
        return {1'b0, code[3:0], rd[2:0], ra[2:0], 1'b0, imm[3:0]};
    endfunction

    function automatic logic [15:0] alu_r(int code, int rd, int ra, int rb);
        return {1'b0, code[3:0], rd[2:0], ra[2:0], 2'b10, rb[2:0]};
    endfunction

    function automatic logic [15:0] ls_i(bit store, int rd, int ra, int imm);
        return {4'b0110, store, rd[2:0], ra[2:0], 1'b0, imm[3:0]};
    endfunction

    function automatic logic [15:0] st_r(int rd, int ra, int rb);
        return {5'b01101, rd[2:0], ra[2:0], 2'b10, rb[2:0]};
    endfunction

    function automatic logic [15:0] br(int cond, int off);
        return {2'b10, cond[3:0], off[9:0]};
    endfunction

    function automatic logic [15:0] sext4(int imm);
        return {{12{imm[3]}}, imm[3:0]};
    endfunction

    // reference alu result
    function automatic logic [15:0] alu_ref(int code, logic [15:0] a, logic [15:0] b);
        case (code)
            0: return a + b;
            1: return a - b;
            2: return a & b;
            3: return a | b;
            4: return a ^ b;
            5: return b;
            6: return a << b[3:0];
            7: return a >> b[3:0];
            default: return a;
        endcase
    endfunction

    // n z c v after a - b, c means no borrow
    function automatic logic [3:0] sub_flags(logic [15:0] a, logic [15:0] b);
        logic [15:0] r;
        int          sd;
        r  = a - b;
        // signed difference outside the 16-bit range is an overflow
        sd = int'($signed(a)) - int'($signed(b));
        return {r[15], r == 16'h0, a >= b, sd > 32767 || sd < -32768};
    endfunction

    // hi and ls test v, as in the reference
    function automatic bit cond_ref(int cond, logic [3:0] f);
        logic n, z, c, v;
        {n, z, c, v} = f;
        case (cond)
            0: return z;
            1: return !z;
            2: return c;
            3: return !c;
            4: return n;
            5: return !n;
            6: return v;
            7: return !v;
            8: return v && !z;
            9: return !v || z;
            10: return n == v;
            11: return n != v;
            12: return !z && (n == v);
            13: return z || (n != v);
            14: return 1'b1;
            default: return 1'b0;
        endcase
    endfunction

    function automatic logic [31:0] xorshift32(logic [31:0] x);
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    task automatic check_value(string what, logic [31:0] got, logic [31:0] exp);
        if (got !== exp) begin
            errors++;
            $display("MISMATCH at %0d ns: %s got %h expected %h", $time, what, got, exp);
            $display("TEST FAILED");
            $fatal(1);
        end
    endtask

    task automatic emit(logic [15:0] word);
        mem[wp] = word;
        wp++;
    endtask

    // hold reset, clear memory and set the base register code
    task automatic start_program();
        clk_gen.assert_reset();
        for (int i = 0; i < 256; i++) begin
            mem[i] = '0;
        end
        wp = 0;
        // r7 = 0xc0, result slots at r7+0..7, constants at r7-8..-1
        emit(alu_i(5, 7, 0, 3));
        emit(alu_i(6, 7, 7, 6));
    endtask

    // done store to 0xff, park in a self loop, run and wait
    task automatic run_program();
        int cycles;
        emit(ls_i(1, 0, 0, -1));
        emit(br(14, -1));
        clk_gen.release_reset();
        cycles = 0;
        while (!(mem_req.we && mem_req.addr[7:0] == 8'hff)) begin
            if (cycles >= DONE_LIMIT) begin
                $display("timeout: program never stored to the done address");
                $display("TEST FAILED");
                $fatal(1);
            end
            @(negedge clk);
            #1;
            cycles++;
        end
        @(posedge clk);
        #1;
    endtask

    task automatic reset_fetch_test();
        clk_gen.assert_reset();
        for (int i = 0; i < 256; i++) begin
            mem[i] = '0;
        end
        fork
            clk_gen.release_reset();
            begin
                repeat (5) begin
                    #1;
                    check_value("re in reset", mem_req.re, 1'b0);
                    check_value("we in reset", mem_req.we, 1'b0);
                    @(negedge clk);
                end
            end
        join
        // zero words decode as add r0, r0, #0
        for (int k = 0; k < 6; k++) begin
            #1;
            check_value("fetch re", mem_req.re, 1'b1);
            check_value("fetch addr", mem_req.addr, k);
            @(negedge clk);
        end
    endtask

    task automatic alu_test(logic [15:0] a, logic [15:0] b, bit use_reg, int imm);
        logic [15:0] bv;
        start_program();
        mem[8'hb8] = a;
        mem[8'hb9] = b;
        emit(ls_i(0, 1, 7, -8));
        emit(ls_i(0, 2, 7, -7));
        for (int code = 0; code < 8; code++) begin
            emit(use_reg ? alu_r(code, 3, 1, 2) : alu_i(code, 3, 1, imm));
            emit(ls_i(1, 3, 7, code));
        end
        run_program();
        bv = use_reg ? b : sext4(imm);
        for (int code = 0; code < 8; code++) begin
            check_value($sformatf("alu code %0d reg %0d", code, use_reg),
                        mem[8'hc0 + code], alu_ref(code, a, bv));
        end
    endtask

    task automatic branch_test(logic [15:0] a, logic [15:0] b);
        logic [3:0] f;
        start_program();
        mem[8'hb8] = a;
        mem[8'hb9] = b;
        emit(ls_i(0, 1, 7, -8));
        emit(ls_i(0, 2, 7, -7));
        emit(alu_i(5, 4, 0, 1));
        // second slot base 0xd0
        emit(alu_i(5, 5, 0, 7));
        emit(alu_i(0, 5, 5, 6));
        emit(alu_i(6, 5, 5, 4));
        emit(alu_r(1, 3, 1, 2));
        for (int c = 0; c < 16; c++) begin
            // taken skips the marker store in the delay slot
            emit(br(c, 1));
            emit(ls_i(1, 4, c < 8 ? 7 : 5, c % 8));
        end
        run_program();
        f = sub_flags(a, b);
        for (int c = 0; c < 16; c++) begin
            check_value($sformatf("cond %0d after %h-%h", c, a, b),
                        mem[(c < 8 ? 8'hc0 : 8'hd0) + c % 8], cond_ref(c, f) ? 0 : 1);
        end
    endtask

    task automatic load_store_test();
        start_program();
        mem[8'hb8] = 16'h1111;
        mem[8'hb9] = 16'h2345;
        emit(ls_i(0, 1, 7, -8));
        emit(ls_i(0, 2, 7, -7));
        // loaded r2 used with no gap
        emit(alu_r(0, 3, 1, 2));
        emit(ls_i(1, 3, 7, 0));
        emit(ls_i(1, 1, 7, 5));
        emit(alu_i(5, 6, 0, 2));
        emit(st_r(2, 7, 6));
        emit(ls_i(1, 1, 7, -2));
        emit(ls_i(0, 4, 7, -7));
        emit(ls_i(1, 4, 7, 7));
        run_program();
        check_value("load and add", mem[8'hc0], 16'h3456);
        check_value("store imm", mem[8'hc5], 16'h1111);
        check_value("store reg offset", mem[8'hc2], 16'h2345);
        check_value("store neg offset", mem[8'hbe], 16'h1111);
        check_value("load then store", mem[8'hc7], 16'h2345);
    endtask

    task automatic random_test(int rounds);
        logic [15:0] model [8];
        logic [15:0] expect_q [8];
        logic [15:0] bv;
        int code, rd, ra, rb, imm;
        bit use_reg;
        for (int r = 0; r < rounds; r++) begin
            start_program();
            for (int i = 0; i < 8; i++) begin
                model[i] = '0;
            end
            model[7] = 16'h00c0;
            for (int i = 0; i < 8; i++) begin
                rng     = xorshift32(rng);
                code    = rng[2:0];
                rd      = 1 + rng[10:8] % 6;
                ra      = rng[13:11] % 7;
                use_reg = rng[16];
                rb      = rng[19:17];
                imm     = rng[23:20];
                bv      = use_reg ? model[rb] : sext4(imm);
                emit(use_reg ? alu_r(code, rd, ra, rb) : alu_i(code, rd, ra, imm));
                emit(ls_i(1, rd, 7, i));
                model[rd]   = alu_ref(code, model[ra], bv);
                expect_q[i] = model[rd];
            end
            run_program();
            for (int i = 0; i < 8; i++) begin
                check_value($sformatf("random round %0d op %0d", r, i),
                            mem[8'hc0 + i], expect_q[i]);
            end
        end
    endtask

    initial begin
        rdata  = '0;
        errors = 0;
        rng    = 32'd53969;
        reset_fetch_test();
        alu_test(16'h8f3c, 16'h7105, 1'b1, 0);
        alu_test(16'hffff, 16'h0001, 1'b1, 0);
        alu_test(16'h8f3c, 16'h0000, 1'b0, -3);
        alu_test(16'h7fff, 16'h0000, 1'b0, 7);
        branch_test(16'h0005, 16'h0005);
        branch_test(16'h0003, 16'h0007);
        branch_test(16'h0007, 16'h0003);
        branch_test(16'h8000, 16'h0001);
        branch_test(16'h7fff, 16'hffff);
        branch_test(16'h0000, 16'h8000);
        load_store_test();
        random_test(4);
        if (errors == 0 && dut0.u_exec.u_chk.fail_count == 0) begin
            $display("TEST PASSED");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

endmodule

// ==== files.f ====
+incdir+design
design/isa_pkg.sv
design/core_pkg.sv
design/fetch_unit.sv
design/exec_unit.sv
design/regfile.sv
design/alu.sv
design/cpu_top.sv
tests/tb_clock.sv
tests/cpu_chk.sv
tests/cpu_tb.sv

// ==== Bender.yml ====
package:
  name: cpu16

sources:
  - include_dirs:
      - design
    files:
      - design/isa_pkg.sv
      - design/core_pkg.sv
      - design/fetch_unit.sv
      - design/exec_unit.sv
      - design/regfile.sv
      - design/alu.sv
      - design/cpu_top.sv
  - target: test
    include_dirs:
      - design
    files:
      - tests/tb_clock.sv
      - tests/cpu_chk.sv
      - tests/cpu_tb.sv
